// File: processor.f
+incdir+common
common/mem_bus_pkg.sv
common/cache_pkg.sv
icache/icache.sv
logic/dmem_port.sv
logic/cache_arbiter.sv
logic/processor.sv
testbench/processor_asserts.sv
testbench/processor_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module processor_tb -f processor.f

status=0
./obj_dir/Vprocessor_tb +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Testbench failed" sim.log || [ "$status" -ne 0 ]; then
    exit 1
fi
exit 0

// File: testbench/processor_tb.sv
/* Testbench for the memory-side top level
   Clock, reset, tagged memory model, random fetch and data traffic, timeout */
`include "proc_consts.svh"

module processor_tb;
    import mem_bus_pkg::*;
    import cache_pkg::*;

    localparam int NUM_FETCH      = 120;
    localparam int NUM_DATA       = 120;
    localparam int TIMEOUT_CYCLES = `REQ_TIMEOUT * (NUM_FETCH + NUM_DATA);

    typedef struct packed {
        logic [`MEM_TAG_BITS-1:0] tag;
        logic [63:0]              data;
        logic [31:0]              due;    // Cycle the reply goes out
    } reply_t;

    logic                     clock = 1'b0;
    logic                     rst_n = 1'b1;
    fetch_req_t               fetch_req = '0;
    data_req_t                data_req = '0;
    mem_rsp_t                 mem_rsp;
    fetch_rsp_t               fetch_rsp;
    data_rsp_t                data_rsp;
    mem_req_t                 mem_req;

    logic [63:0]              mem [256];
    reply_t                   replies [$];
    logic                     accept_ok = 1'b0;
    logic [`MEM_TAG_BITS-1:0] next_tag = 4'h1;
    logic [`MEM_TAG_BITS-1:0] rsp_tag = '0;
    logic [63:0]              rsp_data = '0;
    logic [`MEM_TAG_BITS-1:0] accept_tag;
    logic [31:0]              mem_rnd;
    logic [31:0]              stim_rnd = 32'd63;
    int                       cycle_count = 0;
    int                       fetch_sent = 0;
    int                       data_sent = 0;
    int                       errors;
    logic                     fetch_busy = 1'b0;
    logic                     data_busy = 1'b0;

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    processor dut_i (
        .clock     (clock),
        .rst_n     (rst_n),
        .fetch_req (fetch_req),
        .data_req  (data_req),
        .mem_rsp   (mem_rsp),
        .fetch_rsp (fetch_rsp),
        .data_rsp  (data_rsp),
        .mem_req   (mem_req)
    );

    bind processor processor_asserts asserts_i (
        .clock     (clock),
        .rst_n     (rst_n),
        .fetch_req (fetch_req),
        .data_req  (data_req),
        .fetch_rsp (fetch_rsp),
        .data_rsp  (data_rsp),
        .mem_req   (mem_req)
    );

    always #4 clock = ~clock;
    always @(posedge clock) cycle_count <= cycle_count + 1;

    //////////////////////////////
    // Memory model
    initial begin
        mem_rnd = next_random(stim_rnd);
        for (int b = 0; b < 256; b++) begin
            mem[b] = {((b * 8) + 32'd4) ^ 32'h5A5A0000, (b * 8) ^ 32'h5A5A0000};
        end
    end

    // Same-cycle accept tag or zero on a reject
    assign accept_tag = (mem_req.command != BUS_NONE && accept_ok) ? next_tag : '0;
    assign mem_rsp    = {accept_tag, rsp_tag, rsp_data};

    always @(posedge clock) begin
        mem_rnd = next_random(mem_rnd);
        if (accept_tag != '0) begin
            if (mem_req.command == BUS_STORE) begin
                mem[mem_req.addr[10:3]] <= mem_req.data.dword;
            end else begin
                replies.push_back('{tag: accept_tag, data: mem[mem_req.addr[10:3]],
                                    due: cycle_count + 32'd1 + (mem_rnd % 32'd6)});
            end
            next_tag <= (next_tag == 4'hF) ? 4'h1 : next_tag + 4'h1;
        end
        accept_ok <= (mem_rnd[4:3] != 2'b00);   // About one reject in four
        if (replies.size() > 0 && replies[0].due <= cycle_count) begin
            rsp_tag  <= replies[0].tag;
            rsp_data <= replies[0].data;
            void'(replies.pop_front());
        end else begin
            rsp_tag <= '0;
        end
    end

    //////////////////////////////
    // Stimulus and closing report
    initial begin
        rst_n <= 1'b0;
        repeat (3) @(posedge clock);
        rst_n <= 1'b1;
        repeat (4) @(posedge clock);   // Idle bus after reset
        while (fetch_sent < NUM_FETCH || data_sent < NUM_DATA || fetch_busy || data_busy) begin
            @(posedge clock);
            if (fetch_rsp.valid) fetch_busy = 1'b0;
            if (data_rsp.valid) data_busy = 1'b0;
            stim_rnd = next_random(stim_rnd);
            fetch_req <= '0;
            data_req  <= '0;
            if (!fetch_busy && fetch_sent < NUM_FETCH && stim_rnd[0]) begin
                fetch_req.valid <= 1'b1;   // Mostly a small window so lines get reused
                fetch_req.pc    <= stim_rnd[8] ? (stim_rnd & 32'h3FC) : (stim_rnd & 32'h7C);
                fetch_busy = 1'b1;
                fetch_sent++;
            end
            if (!data_busy && data_sent < NUM_DATA && stim_rnd[1]) begin
                data_req.valid <= 1'b1;
                data_req.store <= stim_rnd[9];
                data_req.addr  <= 32'h400 | (stim_rnd & 32'h78);
                data_req.data  <= {next_random(stim_rnd), ~stim_rnd};
                data_busy = 1'b1;
                data_sent++;
            end
        end
        repeat (4) @(posedge clock);
        errors = dut_i.asserts_i.error_count;
        $display("Done: %0d fetches, %0d data accesses, %0d errors",
                 fetch_sent, data_sent, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("Timeout: a request got no reply within %0d cycles", cycle_count);
        $display("Testbench failed");
        $finish;
    end

endmodule

// File: testbench/processor_asserts.sv
/* Bound checker for the memory-side top level
   Shadow memory, icache line tracking and concurrent assertions */
`include "proc_consts.svh"

module processor_asserts (
    input  logic                   clock,
    input  logic                   rst_n,
    input  cache_pkg::fetch_req_t  fetch_req,
    input  cache_pkg::data_req_t   data_req,
    input  cache_pkg::fetch_rsp_t  fetch_rsp,
    input  cache_pkg::data_rsp_t   data_rsp,
    input  mem_bus_pkg::mem_req_t  mem_req
);
    import mem_bus_pkg::*;
    import cache_pkg::*;

    int unsigned                   error_count = 0;
    logic                          seen_req;       // Any strobe since reset
    logic                          fetch_out;
    logic                          data_out;
    logic [`XLEN-1:0]              fetch_pc;
    logic [63:0]                   exp_data;       // Zero for stores
    logic [63:0]                   shadow [256];
    logic                          line_valid [`ICACHE_LINES];
    logic [`ICACHE_TAG_BITS-1:0]   line_tag [`ICACHE_LINES];
    logic [63:0]                   fetch_block;
    logic [31:0]                   exp_inst;
    logic                          expect_hit;

    // Power-on content of the doubleword at block address blk
    function automatic logic [63:0] block_pattern(input logic [31:0] blk);
        return {(blk + 32'd4) ^ 32'h5A5A0000, blk ^ 32'h5A5A0000};
    endfunction

    assign fetch_block = block_pattern({fetch_pc[31:3], 3'b000});
    assign exp_inst    = fetch_pc[2] ? fetch_block[63:32] : fetch_block[31:0];
    assign expect_hit  = line_valid[fetch_req.pc[`BLOCK_BITS +: `ICACHE_IDX_BITS]]
                         && (line_tag[fetch_req.pc[`BLOCK_BITS +: `ICACHE_IDX_BITS]]
                             == fetch_req.pc[`XLEN-1 -: `ICACHE_TAG_BITS]);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            seen_req  <= 1'b0;
            fetch_out <= 1'b0;
            data_out  <= 1'b0;
            fetch_pc  <= '0;
            exp_data  <= '0;
            for (int i = 0; i < `ICACHE_LINES; i++) begin
                line_valid[i] <= 1'b0;
                line_tag[i]   <= '0;
            end
            for (int b = 0; b < 256; b++) begin
                shadow[b] <= block_pattern(b * 8);
            end
        end else begin
            if (fetch_req.valid || data_req.valid) seen_req <= 1'b1;
            if (fetch_rsp.valid) begin  // Line now holds the block of fetch_pc
                fetch_out <= 1'b0;
                line_valid[fetch_pc[`BLOCK_BITS +: `ICACHE_IDX_BITS]] <= 1'b1;
                line_tag[fetch_pc[`BLOCK_BITS +: `ICACHE_IDX_BITS]]
                    <= fetch_pc[`XLEN-1 -: `ICACHE_TAG_BITS];
            end
            if (fetch_req.valid) begin
                fetch_out <= 1'b1;
                fetch_pc  <= fetch_req.pc;
            end
            if (data_rsp.valid) data_out <= 1'b0;
            if (data_req.valid) begin
                data_out <= 1'b1;
                if (data_req.store) begin
                    shadow[data_req.addr[10:3]] <= data_req.data;
                    exp_data                    <= '0;
                end else begin
                    exp_data <= shadow[data_req.addr[10:3]];
                end
            end
        end
    end

    //////////////////////////////
    // Assertions
    reset_idle: assert property (@(posedge clock) disable iff (!rst_n)
        !seen_req |-> (mem_req.command == BUS_NONE) && !fetch_rsp.valid && !data_rsp.valid)
    else begin
        $error("FAILED reset_idle: expected cmd/fetch/data 0/0/0, actual %0d/%0b/%0b",
               $sampled(mem_req.command), $sampled(fetch_rsp.valid), $sampled(data_rsp.valid));
        error_count++;
    end

    // Every bus access moves one whole doubleword
    bus_size: assert property (@(posedge clock) disable iff (!rst_n)
        mem_req.command != BUS_NONE |-> mem_req.size == DOUBLE)
    else begin
        $error("FAILED bus_size: expected %0d, actual %0d",
               DOUBLE, $sampled(mem_req.size));
        error_count++;
    end

    fetch_word: assert property (@(posedge clock) disable iff (!rst_n)
        fetch_rsp.valid |-> fetch_rsp.inst == exp_inst)
    else begin
        $error("FAILED fetch_word: expected %08h, actual %08h",
               $sampled(exp_inst), $sampled(fetch_rsp.inst));
        error_count++;
    end

    fetch_hit_timing: assert property (@(posedge clock) disable iff (!rst_n)
        fetch_req.valid && expect_hit |=> fetch_rsp.valid)
    else begin
        $error("FAILED fetch_hit_timing: expected reply strobe 1, actual %0b",
               $sampled(fetch_rsp.valid));
        error_count++;
    end

    load_data: assert property (@(posedge clock) disable iff (!rst_n)
        data_rsp.valid |-> data_rsp.data == exp_data)
    else begin
        $error("FAILED load_data: expected %016h, actual %016h",
               $sampled(exp_data), $sampled(data_rsp.data));
        error_count++;
    end

    fetch_one_reply: assert property (@(posedge clock) disable iff (!rst_n)
        fetch_rsp.valid |-> fetch_out)
    else begin
        $error("FAILED fetch_one_reply: expected outstanding 1, actual %0b",
               $sampled(fetch_out));
        error_count++;
    end

    data_one_reply: assert property (@(posedge clock) disable iff (!rst_n)
        data_rsp.valid |-> data_out)
    else begin
        $error("FAILED data_one_reply: expected outstanding 1, actual %0b",
               $sampled(data_out));
        error_count++;
    end

endmodule

// File: logic/processor.sv
/* Memory-side top level
   Instruction cache, data port and the shared bus arbiter */
module processor (
    input  logic                   clock,
    input  logic                   rst_n,
    input  cache_pkg::fetch_req_t  fetch_req,
    input  cache_pkg::data_req_t   data_req,
    input  mem_bus_pkg::mem_rsp_t  mem_rsp,      // Accept tag, reply tag, data
    output cache_pkg::fetch_rsp_t  fetch_rsp,
    output cache_pkg::data_rsp_t   data_rsp,
    output mem_bus_pkg::mem_req_t  mem_req
);
    import mem_bus_pkg::*;

    mem_req_t  imem_req;
    mem_req_t  dmem_req;
    mem_rsp_t  imem_rsp;
    mem_rsp_t  dmem_rsp;
    logic      imem_granted;
    logic      dmem_granted;

    //////////////////////////////
    // Requesters
    icache icache_0 (
        .clock        (clock),
        .rst_n        (rst_n),
        .fetch_req    (fetch_req),
        .fetch_rsp    (fetch_rsp),
        .imem_req     (imem_req),
        .imem_rsp     (imem_rsp),
        .imem_granted (imem_granted)
    );

    dmem_port dmem_port_0 (
        .clock        (clock),
        .rst_n        (rst_n),
        .data_req     (data_req),
        .data_rsp     (data_rsp),
        .dmem_req     (dmem_req),
        .dmem_rsp     (dmem_rsp),
        .dmem_granted (dmem_granted)
    );

    //////////////////////////////
    // Shared bus
    cache_arbiter cache_arbiter_0 (
        .dmem_req     (dmem_req),
        .imem_req     (imem_req),
        .mem_rsp      (mem_rsp),
        .mem_req      (mem_req),
        .imem_granted (imem_granted),
        .dmem_granted (dmem_granted),
        .imem_rsp     (imem_rsp),
        .dmem_rsp     (dmem_rsp)
    );

endmodule

// File: logic/cache_arbiter.sv
/* Memory bus arbiter
   Data-first grant, response tag steering and reply broadcast */
module cache_arbiter (
    input  mem_bus_pkg::mem_req_t  dmem_req,
    input  mem_bus_pkg::mem_req_t  imem_req,
    input  mem_bus_pkg::mem_rsp_t  mem_rsp,
    output mem_bus_pkg::mem_req_t  mem_req,
    output logic                   imem_granted,
    output logic                   dmem_granted,
    output mem_bus_pkg::mem_rsp_t  imem_rsp,
    output mem_bus_pkg::mem_rsp_t  dmem_rsp
);
    import mem_bus_pkg::*;

    //////////////////////////////
    // Grant
    // Data side wins whenever it asks and icache takes the idle bus
    assign dmem_granted = (dmem_req.command != BUS_NONE);
    assign imem_granted = !dmem_granted && (imem_req.command != BUS_NONE);

    assign mem_req = dmem_granted ? dmem_req : imem_req;

    //////////////////////////////
    // Replies
    // Reply tag and data go to both sides and each matches its own tag.
    // The accept tag only reaches the side that owned the bus this cycle,
    // so a loser sees a reject and tries again next cycle.
    always_comb begin
        dmem_rsp = mem_rsp;
        imem_rsp = mem_rsp;

        if (!dmem_granted) begin
            dmem_rsp.response = '0;
        end
        if (!imem_granted) begin
            imem_rsp.response = '0;
        end
    end

endmodule

// File: logic/dmem_port.sv
/* Data-side memory port
   One outstanding uncached doubleword load or store, retried until accepted */
`include "proc_consts.svh"

module dmem_port (
    input  logic                   clock,
    input  logic                   rst_n,
    input  cache_pkg::data_req_t   data_req,
    output cache_pkg::data_rsp_t   data_rsp,
    output mem_bus_pkg::mem_req_t  dmem_req,
    input  mem_bus_pkg::mem_rsp_t  dmem_rsp,
    input  logic                   dmem_granted
);
    import mem_bus_pkg::*;

    logic                           busy;
    logic [`MEM_TAG_BITS-1:0]       pend_mem_tag;   // Load tag or zero while unsent
    logic                           req_store;
    logic [`XLEN-1:`BLOCK_BITS]     req_blk;        // Doubleword address
    logic [63:0]                    req_data;
    logic                           take;
    logic                           accepted;
    logic                           reply;

    assign take = data_req.valid && !busy;  // Strobes while busy are dropped

    always_comb begin
        dmem_req            = '0;
        if (busy && pend_mem_tag == '0) begin
            dmem_req.command = req_store ? BUS_STORE : BUS_LOAD;
        end
        dmem_req.addr       = {req_blk, {`BLOCK_BITS{1'b0}}};
        dmem_req.size       = DOUBLE;
        dmem_req.data.dword = req_data;
    end

    assign accepted = (dmem_req.command != BUS_NONE) && dmem_granted
                      && (dmem_rsp.response != '0);
    assign reply    = busy && (pend_mem_tag != '0) && (dmem_rsp.tag == pend_mem_tag);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            busy         <= 1'b0;
            pend_mem_tag <= '0;
            data_rsp     <= '0;
        end else begin
            data_rsp.valid <= 1'b0;
            if (take) busy <= 1'b1;

            if (accepted) begin
                if (req_store) begin  // Stores finish on accept
                    busy           <= 1'b0;
                    data_rsp.valid <= 1'b1;
                    data_rsp.data  <= '0;
                end else begin
                    pend_mem_tag <= dmem_rsp.response;
                end
            end

            if (reply) begin
                busy           <= 1'b0;
                pend_mem_tag   <= '0;
                data_rsp.valid <= 1'b1;
                data_rsp.data  <= dmem_rsp.data.dword;
            end
        end
    end

    // Request payload
    always_ff @(posedge clock) begin
        if (take) begin
            req_store <= data_req.store;
            req_blk   <= data_req.addr[`XLEN-1:`BLOCK_BITS];
            req_data  <= data_req.data;
        end
    end

endmodule

// File: icache/icache.sv
/* Direct-mapped instruction cache
   Hit path, miss fill over the tagged memory bus, outstanding tag tracking */
`include "proc_consts.svh"

module icache (
    input  logic                   clock,
    input  logic                   rst_n,
    input  cache_pkg::fetch_req_t  fetch_req,
    output cache_pkg::fetch_rsp_t  fetch_rsp,
    output mem_bus_pkg::mem_req_t  imem_req,
    input  mem_bus_pkg::mem_rsp_t  imem_rsp,
    input  logic                   imem_granted
);
    import mem_bus_pkg::*;
    import cache_pkg::*;

    icache_line_t                  lines [`ICACHE_LINES];
    icache_line_t                  hit_line;
    logic [`ICACHE_IDX_BITS-1:0]   req_idx;
    logic [`ICACHE_TAG_BITS-1:0]   req_tag;
    logic                          hit;

    logic                          pending;        // Miss in progress
    logic [`XLEN-1:0]              pend_pc;
    logic [`ICACHE_IDX_BITS-1:0]   pend_idx;
    logic [`MEM_TAG_BITS-1:0]      pend_mem_tag;   // Zero until memory accepts
    logic                          accepted;
    logic                          fill;

    //////////////////////////////
    // Lookup
    assign req_idx  = fetch_req.pc[`BLOCK_BITS +: `ICACHE_IDX_BITS];
    assign req_tag  = fetch_req.pc[`XLEN-1 -: `ICACHE_TAG_BITS];
    assign hit_line = lines[req_idx];
    assign hit      = hit_line.valid && (hit_line.tag == req_tag);
    assign pend_idx = pend_pc[`BLOCK_BITS +: `ICACHE_IDX_BITS];

    //////////////////////////////
    // Bus side
    // Load stays up until a nonzero response tag comes back
    always_comb begin
        imem_req         = '0;
        imem_req.command = (pending && pend_mem_tag == '0) ? BUS_LOAD : BUS_NONE;
        imem_req.addr    = {pend_pc[`XLEN-1:`BLOCK_BITS], {`BLOCK_BITS{1'b0}}};
        imem_req.size    = DOUBLE;
    end

    assign accepted = (imem_req.command == BUS_LOAD) && imem_granted
                      && (imem_rsp.response != '0);
    assign fill     = pending && (pend_mem_tag != '0) && (imem_rsp.tag == pend_mem_tag);

    //////////////////////////////
    // Control, lines and reply
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pending      <= 1'b0;
            pend_mem_tag <= '0;
            fetch_rsp    <= '0;
            for (int i = 0; i < `ICACHE_LINES; i++) begin
                lines[i] <= '0;  // All lines invalid
            end
        end else begin
            fetch_rsp.valid <= 1'b0;

            if (fetch_req.valid && !pending) begin
                if (hit) begin
                    fetch_rsp.valid <= 1'b1;
                    fetch_rsp.inst  <= hit_line.block.insts[fetch_req.pc[`BLOCK_BITS-1]];
                end else begin
                    pending <= 1'b1;
                end
            end

            if (accepted) begin
                pend_mem_tag <= imem_rsp.response;
            end

            // Reply for our tag writes the line and answers next cycle
            if (fill) begin
                lines[pend_idx].valid <= 1'b1;
                lines[pend_idx].tag   <= pend_pc[`XLEN-1 -: `ICACHE_TAG_BITS];
                lines[pend_idx].block <= imem_rsp.data;
                fetch_rsp.valid       <= 1'b1;
                fetch_rsp.inst        <= imem_rsp.data.insts[pend_pc[`BLOCK_BITS-1]];
                pending               <= 1'b0;
                pend_mem_tag          <= '0;
            end
        end
    end

    // Missing pc captured with the strobe
    always_ff @(posedge clock) begin
        if (fetch_req.valid && !pending && !hit) begin
            pend_pc <= fetch_req.pc;
        end
    end

endmodule

// File: common/cache_pkg.sv
/* Requester-side types
   Fetch and data request and reply strobes, icache line layout */
`include "proc_consts.svh"

package cache_pkg;

    //////////////////////////////
    // Fetch side
    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] pc;
    } fetch_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] inst;
    } fetch_rsp_t;

    //////////////////////////////
    // Data side
    typedef struct packed {
        logic             valid;
        logic             store;   // Load when clear
        logic [`XLEN-1:0] addr;
        logic [63:0]      data;    // Store data only
    } data_req_t;

    typedef struct packed {
        logic        valid;
        logic [63:0] data;
    } data_rsp_t;

    // One direct-mapped line holds a single doubleword
    typedef struct packed {
        logic                          valid;
        logic [`ICACHE_TAG_BITS-1:0]   tag;
        mem_bus_pkg::mem_dword_u       block;
    } icache_line_t;

endpackage

// File: common/mem_bus_pkg.sv
/* Memory bus types
   Command and size encodings, doubleword views, request and reply structs */
`include "proc_consts.svh"

package mem_bus_pkg;

    typedef enum logic [1:0] {
        BUS_NONE  = 2'h0,
        BUS_LOAD  = 2'h1,
        BUS_STORE = 2'h2
    } bus_command_t;

    typedef enum logic [1:0] {
        BYTE   = 2'h0,
        HALF   = 2'h1,
        WORD   = 2'h2,
        DOUBLE = 2'h3
    } mem_size_t;

    // One bus doubleword fetched as two instructions or moved as data
    typedef union packed {
        logic [1:0][31:0] insts;   // insts[0] sits at the lower address
        logic [63:0]      dword;
    } mem_dword_u;

    typedef struct packed {
        bus_command_t         command;
        logic [`XLEN-1:0]     addr;
        mem_size_t            size;
        mem_dword_u           data;
    } mem_req_t;

    typedef struct packed {
        logic [`MEM_TAG_BITS-1:0] response;  // Same-cycle accept tag
        logic [`MEM_TAG_BITS-1:0] tag;       // Tag of the reply in flight
        mem_dword_u               data;
    } mem_rsp_t;

endpackage

// File: common/proc_consts.svh
/* Shared constants
   Address width, icache geometry, memory tag width and run timeout */
`ifndef PROC_CONSTS_SVH
`define PROC_CONSTS_SVH

// Address and block
`define XLEN             32
`define BLOCK_BITS       3     // Byte offset inside a doubleword

// Instruction cache geometry
`define ICACHE_LINES     8
`define ICACHE_IDX_BITS  3
`define ICACHE_TAG_BITS  (`XLEN - `ICACHE_IDX_BITS - `BLOCK_BITS)

// Memory bus tags where zero means no tag
`define MEM_TAG_BITS     4

// Allowed cycles per request before a run is abandoned
`define REQ_TIMEOUT      60

`endif
